//--- include/capture_defs.svh
`ifndef CAPTURE_DEFS_SVH
`define CAPTURE_DEFS_SVH

// host and DDR line
`define CAP_LINE_W      512
`define CAP_BEAT_W      64
`define CAP_BEATS       8
`define CAP_LINE_BYTES  64
`define CAP_DDR_ADDR_W  64

// OCL byte addresses, register index times four
`define CSR_ADDR_DONE   32'd4
`define CSR_ADDR_INJECT 32'd8
`define CSR_ADDR_ALLOW  32'd12

`endif

//--- design/stream_pkg.sv
`include "capture_defs.svh"

package stream_pkg;

    typedef logic [`CAP_BEAT_W-1:0] beat_t;
    typedef logic [`CAP_LINE_W-1:0] line_t;

    // lane of a beat inside its line
    typedef logic [$clog2(`CAP_BEATS)-1:0] beat_idx_t;

    typedef enum logic [1:0] {ARB_IDLE, ARB_FWD_A, ARB_FWD_B} arb_state_e;

    typedef enum logic {PW_IDLE, PW_SEND} pcis_w_state_e;

    typedef enum logic [1:0] {PA_IDLE, PA_WAIT_W, PA_SEND_B} pcis_aw_state_e;

    typedef enum logic [1:0] {DW_IDLE, DW_ADDR, DW_DATA} ddr_wr_state_e;

endpackage

//--- design/csr_pkg.sv
package csr_pkg;

    // index 0 is unused
    typedef enum logic [1:0] {
        DONE        = 2'd1,
        INJECT      = 2'd2,
        ALLOW_DDR_W = 2'd3
    } csr_idx_e;

    typedef struct packed {
        logic allow_ddr_w;
        logic app_done;
    } app_csrs_t;

    typedef enum logic [1:0] {OW_IDLE, OW_WAIT_W, OW_INJECT, OW_RESP} ocl_w_state_e;

endpackage

//--- design/beat_stream_if.sv
`timescale 1ns/1ps

interface beat_stream_if import stream_pkg::*; ();

    beat_t tdata;
    logic  tvalid;
    logic  tready;
    logic  tlast;

    modport src (output tdata, output tvalid, output tlast, input tready);

    modport sink (input tdata, input tvalid, input tlast, output tready);

endinterface

//--- design/pcis_write_slave.sv
`timescale 1ns/1ps
`include "capture_defs.svh"

module pcis_write_slave import stream_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic [5:0]  awid,
    input  logic [7:0]  awlen,
    input  logic        awvalid,
    output logic        awready,
    input  line_t       wdata,
    input  logic        wlast,
    input  logic        wvalid,
    output logic        wready,
    output logic [5:0]  bid,
    output logic        bvalid,
    input  logic        bready,
    beat_stream_if.src  bs
);

    pcis_aw_state_e aw_state;
    pcis_w_state_e  w_state;
    logic [7:0]     len_left;
    logic [5:0]     id_q;
    line_t          line_q;
    logic           last_q;
    beat_idx_t      idx;
    logic           w_hs;
    logic           bs_hs;

    assign w_hs  = wvalid && wready;
    assign bs_hs = bs.tvalid && bs.tready;

    // burst tracking, one B per burst
    always_ff @(posedge clk) begin
        if (!rstn) begin
            aw_state <= PA_IDLE;
        end else begin
            case (aw_state)
                PA_IDLE:
                    if (awvalid)
                        aw_state <= PA_WAIT_W;
                PA_WAIT_W:
                    if (w_hs && len_left == 8'd0)
                        aw_state <= PA_SEND_B;
                PA_SEND_B:
                    if (bready)
                        aw_state <= PA_IDLE;
                default:
                    aw_state <= PA_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            len_left <= awlen;
            id_q     <= awid;
        end else if (w_hs) begin
            len_left <= len_left - 8'd1;
        end
    end

    // one line in flight, sent lowest lane first
    always_ff @(posedge clk) begin
        if (!rstn) begin
            w_state <= PW_IDLE;
            idx     <= '0;
        end else begin
            case (w_state)
                PW_IDLE:
                    if (w_hs)
                        w_state <= PW_SEND;
                PW_SEND:
                    if (bs_hs) begin
                        idx <= idx + 1'b1;
                        if (idx == beat_idx_t'(`CAP_BEATS - 1))
                            w_state <= PW_IDLE;
                    end
                default:
                    w_state <= PW_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (w_hs) begin
            line_q <= wdata;
            last_q <= wlast;
        end
    end

    assign awready = (aw_state == PA_IDLE);
    assign wready  = (w_state == PW_IDLE) && (aw_state == PA_WAIT_W);
    assign bvalid  = (aw_state == PA_SEND_B);
    assign bid     = id_q;

    assign bs.tdata  = line_q[idx * `CAP_BEAT_W +: `CAP_BEAT_W];
    assign bs.tvalid = (w_state == PW_SEND);
    assign bs.tlast  = last_q && (idx == beat_idx_t'(`CAP_BEATS - 1));

    // a line needs at least eight cycles to drain
    a_wready_line: assert property (@(posedge clk) disable iff (!rstn)
        w_hs |=> !wready [*`CAP_BEATS])
        else $error("wready high while line buffer streams");

endmodule

//--- design/ocl_csr.sv
`timescale 1ns/1ps
`include "capture_defs.svh"

module ocl_csr import stream_pkg::*, csr_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic        bvalid,
    input  logic        bready,
    output logic [31:0] inject_cnt,
    output app_csrs_t   csrs,
    beat_stream_if.src  bs
);

    ocl_w_state_e state;
    csr_idx_e     sel_d;
    csr_idx_e     sel_q;
    logic         hit_d;
    logic         hit_q;
    beat_t        inj_q;
    logic         w_hs;

    assign w_hs = wvalid && wready;

    // address decode, unknown addresses still get a response
    always_comb begin
        hit_d = 1'b1;
        sel_d = DONE;
        case (awaddr)
            `CSR_ADDR_DONE:   sel_d = DONE;
            `CSR_ADDR_INJECT: sel_d = INJECT;
            `CSR_ADDR_ALLOW:  sel_d = ALLOW_DDR_W;
            default:          hit_d = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= OW_IDLE;
            hit_q <= 1'b0;
            sel_q <= DONE;
        end else begin
            case (state)
                OW_IDLE:
                    if (awvalid) begin
                        state <= OW_WAIT_W;
                        hit_q <= hit_d;
                        sel_q <= sel_d;
                    end
                OW_WAIT_W:
                    if (wvalid)
                        state <= (hit_q && sel_q == INJECT) ? OW_INJECT : OW_RESP;
                OW_INJECT:
                    if (bs.tready)
                        state <= OW_RESP;
                OW_RESP:
                    if (bready)
                        state <= OW_IDLE;
                default:
                    state <= OW_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            csrs       <= '0;
            inject_cnt <= '0;
        end else if (w_hs && hit_q) begin
            case (sel_q)
                DONE:        csrs.app_done    <= 1'b1;
                ALLOW_DDR_W: csrs.allow_ddr_w <= 1'b1;
                INJECT:      inject_cnt       <= inject_cnt + 32'd1;
                default:     csrs             <= csrs;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (w_hs)
            inj_q <= {{(`CAP_BEAT_W - 32){1'b0}}, wdata};
    end

    assign awready = (state == OW_IDLE);
    assign wready  = (state == OW_WAIT_W);
    assign bvalid  = (state == OW_RESP);

    // injected word is a packet of its own
    assign bs.tdata  = inj_q;
    assign bs.tvalid = (state == OW_INJECT);
    assign bs.tlast  = 1'b1;

endmodule

//--- design/stream_arbiter.sv
`timescale 1ns/1ps

module stream_arbiter import stream_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    beat_stream_if.sink in_a,
    beat_stream_if.sink in_b,
    beat_stream_if.src  out
);

    arb_state_e state;
    logic       pick_a;

    // A has priority while idle
    assign pick_a = (state == ARB_FWD_A) || (state == ARB_IDLE && in_a.tvalid);

    always_comb begin
        if (pick_a) begin
            out.tdata   = in_a.tdata;
            out.tvalid  = in_a.tvalid;
            out.tlast   = in_a.tlast;
            in_a.tready = out.tready;
            in_b.tready = 1'b0;
        end else begin
            out.tdata   = in_b.tdata;
            out.tvalid  = in_b.tvalid;
            out.tlast   = in_b.tlast;
            in_b.tready = out.tready;
            in_a.tready = 1'b0;
        end
    end

    // a stalled beat also locks, so a waiting B beat is not pre-empted
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= ARB_IDLE;
        end else begin
            case (state)
                ARB_IDLE:
                    if (out.tvalid && !(out.tready && out.tlast))
                        state <= pick_a ? ARB_FWD_A : ARB_FWD_B;
                ARB_FWD_A, ARB_FWD_B:
                    if (out.tvalid && out.tready && out.tlast)
                        state <= ARB_IDLE;
                default:
                    state <= ARB_IDLE;
            endcase
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (!rstn)
        out.tvalid && !out.tready |=> out.tvalid && $stable(out.tdata) && $stable(out.tlast))
        else $error("merged beat changed while stalled");

endmodule

//--- design/ddr_line_writer.sv
`timescale 1ns/1ps
`include "capture_defs.svh"

module ddr_line_writer import stream_pkg::*, csr_pkg::*; (
    input  logic                       clk,
    input  logic                       rstn,
    input  app_csrs_t                  csrs,
    input  logic                       flush,
    output logic [`CAP_DDR_ADDR_W-1:0] awaddr,
    output logic                       awvalid,
    input  logic                       awready,
    output line_t                      wdata,
    output logic                       wvalid,
    input  logic                       wready,
    beat_stream_if.sink                bs
);

    ddr_wr_state_e state;
    line_t         line_q;
    beat_idx_t     idx;
    logic          aw_hs;
    logic          w_hs;
    logic          bs_hs;

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign bs_hs = bs.tvalid && bs.tready;

    // address only goes out once a beat is waiting
    assign awvalid   = (state == DW_ADDR) && bs.tvalid;
    assign bs.tready = (state == DW_DATA) && !wvalid;
    assign wdata     = line_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= DW_IDLE;
        end else begin
            case (state)
                DW_IDLE:
                    if (csrs.allow_ddr_w)
                        state <= DW_ADDR;
                DW_ADDR:
                    if (aw_hs)
                        state <= DW_DATA;
                DW_DATA:
                    if (w_hs)
                        state <= DW_ADDR;
                default:
                    state <= DW_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            awaddr <= '0;
        end else if (aw_hs) begin
            awaddr <= awaddr + `CAP_DDR_ADDR_W'(`CAP_LINE_BYTES);
        end
    end

    // full line, or a partial one once the flush arrives
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wvalid <= 1'b0;
            idx    <= '0;
        end else if (bs_hs) begin
            idx <= idx + 1'b1;
            if (idx == beat_idx_t'(`CAP_BEATS - 1))
                wvalid <= 1'b1;
        end else if (flush && state == DW_DATA && !wvalid && idx != '0) begin
            wvalid <= 1'b1;
            idx    <= '0;
        end else if (w_hs) begin
            wvalid <= 1'b0;
        end
    end

    // unfilled lanes keep stale data
    always_ff @(posedge clk) begin
        if (bs_hs)
            line_q[idx * `CAP_BEAT_W +: `CAP_BEAT_W] <= bs.tdata;
    end

    a_aw_w_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(awvalid && wvalid))
        else $error("awvalid and wvalid high together");

endmodule

//--- design/capture_top.sv
`timescale 1ns/1ps
`include "capture_defs.svh"

module capture_top import csr_pkg::*; (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic [5:0]                 pcis_awid,
    input  logic [7:0]                 pcis_awlen,
    input  logic                       pcis_awvalid,
    output logic                       pcis_awready,
    input  logic [`CAP_LINE_W-1:0]     pcis_wdata,
    input  logic                       pcis_wlast,
    input  logic                       pcis_wvalid,
    output logic                       pcis_wready,
    output logic [5:0]                 pcis_bid,
    output logic                       pcis_bvalid,
    input  logic                       pcis_bready,
    input  logic [31:0]                ocl_awaddr,
    input  logic                       ocl_awvalid,
    output logic                       ocl_awready,
    input  logic [31:0]                ocl_wdata,
    input  logic                       ocl_wvalid,
    output logic                       ocl_wready,
    output logic                       ocl_bvalid,
    input  logic                       ocl_bready,
    output logic [`CAP_DDR_ADDR_W-1:0] ddr_awaddr,
    output logic                       ddr_awvalid,
    input  logic                       ddr_awready,
    output logic [`CAP_LINE_W-1:0]     ddr_wdata,
    output logic                       ddr_wvalid,
    input  logic                       ddr_wready,
    output logic                       irq_req
);

    beat_stream_if pcis_bs ();
    beat_stream_if ocl_bs ();
    beat_stream_if merged_bs ();

    app_csrs_t   csrs;
    logic [31:0] inject_cnt;
    logic [31:0] pcis_beats;
    logic [31:0] ddr_beats;
    logic [31:0] ddr_beats_now;
    logic        ddr_w_hs;
    logic        flush;
    logic        flush_taken;
    logic        irq_set;
    logic        irq_set_q;

    pcis_write_slave u_pcis (
        .clk     (clk),
        .rstn    (rstn),
        .awid    (pcis_awid),
        .awlen   (pcis_awlen),
        .awvalid (pcis_awvalid),
        .awready (pcis_awready),
        .wdata   (pcis_wdata),
        .wlast   (pcis_wlast),
        .wvalid  (pcis_wvalid),
        .wready  (pcis_wready),
        .bid     (pcis_bid),
        .bvalid  (pcis_bvalid),
        .bready  (pcis_bready),
        .bs      (pcis_bs)
    );

    ocl_csr u_ocl (
        .clk        (clk),
        .rstn       (rstn),
        .awaddr     (ocl_awaddr),
        .awvalid    (ocl_awvalid),
        .awready    (ocl_awready),
        .wdata      (ocl_wdata),
        .wvalid     (ocl_wvalid),
        .wready     (ocl_wready),
        .bvalid     (ocl_bvalid),
        .bready     (ocl_bready),
        .inject_cnt (inject_cnt),
        .csrs       (csrs),
        .bs         (ocl_bs)
    );

    stream_arbiter u_arb (
        .clk  (clk),
        .rstn (rstn),
        .in_a (ocl_bs),
        .in_b (pcis_bs),
        .out  (merged_bs)
    );

    ddr_line_writer u_writer (
        .clk     (clk),
        .rstn    (rstn),
        .csrs    (csrs),
        .flush   (flush),
        .awaddr  (ddr_awaddr),
        .awvalid (ddr_awvalid),
        .awready (ddr_awready),
        .wdata   (ddr_wdata),
        .wvalid  (ddr_wvalid),
        .wready  (ddr_wready),
        .bs      (merged_bs)
    );

    assign ddr_w_hs = ddr_wvalid && ddr_wready;

    // includes a DDR line accepted in this cycle
    assign ddr_beats_now = ddr_beats + (ddr_w_hs ? 32'(`CAP_BEATS) : 32'd0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pcis_beats <= '0;
            ddr_beats  <= '0;
        end else begin
            if (pcis_wvalid && pcis_wready)
                pcis_beats <= pcis_beats + 32'(`CAP_BEATS);
            ddr_beats <= ddr_beats_now;
        end
    end

    // flush ends once a line has gone out under it
    assign flush = csrs.app_done && !pcis_bs.tvalid && !ocl_bs.tvalid &&
                   !merged_bs.tvalid && !flush_taken;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            flush_taken <= 1'b0;
            irq_set     <= 1'b0;
            irq_set_q   <= 1'b0;
        end else begin
            if (flush && ddr_w_hs)
                flush_taken <= 1'b1;
            if (flush && ddr_beats_now >= pcis_beats + inject_cnt)
                irq_set <= 1'b1;
            irq_set_q <= irq_set;
        end
    end

    // rising edge of the set-once flag
    assign irq_req = irq_set && !irq_set_q;

endmodule

//--- tests/capture_checker.sv
`timescale 1ns/1ps
`include "capture_defs.svh"

module capture_checker (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic [5:0]                 pcis_awid,
    input  logic                       pcis_awvalid,
    input  logic                       pcis_awready,
    input  logic [`CAP_LINE_W-1:0]     pcis_wdata,
    input  logic                       pcis_wvalid,
    input  logic                       pcis_wready,
    input  logic [5:0]                 pcis_bid,
    input  logic                       pcis_bvalid,
    input  logic                       pcis_bready,
    input  logic [31:0]                ocl_awaddr,
    input  logic                       ocl_awvalid,
    input  logic                       ocl_awready,
    input  logic [31:0]                ocl_wdata,
    input  logic                       ocl_wvalid,
    input  logic                       ocl_wready,
    input  logic                       ocl_bvalid,
    input  logic                       ocl_bready,
    input  logic [`CAP_DDR_ADDR_W-1:0] ddr_awaddr,
    input  logic                       ddr_awvalid,
    input  logic                       ddr_awready,
    input  logic [`CAP_LINE_W-1:0]     ddr_wdata,
    input  logic                       ddr_wvalid,
    input  logic                       ddr_wready,
    input  logic                       irq_req,
    input  logic                       final_check,
    input  int                         exp_beats,
    input  int                         exp_bursts,
    input  int                         exp_ocl_writes,
    output int                         errors
);

    // beats in the order they entered the stream
    logic [`CAP_BEAT_W-1:0] ref_q[$];
    logic [5:0]             id_q[$];
    logic [31:0]            ocl_addr;
    bit                     allow_seen;
    bit                     done_seen;
    bit                     irq_prev;
    bit                     checked;
    int                     pcis_b_cnt;
    int                     ocl_aw_cnt;
    int                     ocl_b_cnt;
    int                     ddr_aw_cnt;
    int                     lines;
    int                     irq_pulses;
    int                     exp_lines;

    assign exp_lines = (exp_beats + `CAP_BEATS - 1) / `CAP_BEATS;

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: expected %h, got %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic failure(input string what);
        errors++;
        $display("[ERROR] %s at %0t", what, $time);
    endtask

    task automatic watch_irq();
        if (irq_req) begin
            if (irq_prev)
                failure("irq_req stayed high for more than one cycle");
            else
                irq_pulses++;
            if (!done_seen)
                failure("irq_req raised before DONE was written");
            check_value("DDR lines written before irq_req", exp_lines, lines);
        end
        irq_prev = irq_req;
    endtask

    task automatic watch_pcis();
        logic [5:0] exp_id;
        if (pcis_awvalid && pcis_awready) begin
            id_q.push_back(pcis_awid);
        end
        // lowest lane leaves first
        if (pcis_wvalid && pcis_wready) begin
            for (int k = 0; k < `CAP_BEATS; k++)
                ref_q.push_back(pcis_wdata[k*`CAP_BEAT_W +: `CAP_BEAT_W]);
        end
        if (pcis_bvalid && pcis_bready) begin
            pcis_b_cnt++;
            if (id_q.size() == 0) begin
                failure("pcis B response without an open burst");
            end else begin
                exp_id = id_q.pop_front();
                check_value("pcis_bid", exp_id, pcis_bid);
            end
        end
    endtask

    task automatic watch_ocl();
        if (ocl_awvalid && ocl_awready) begin
            ocl_addr = ocl_awaddr;
            ocl_aw_cnt++;
        end
        if (ocl_wvalid && ocl_wready) begin
            case (ocl_addr)
                `CSR_ADDR_INJECT: ref_q.push_back({{(`CAP_BEAT_W - 32){1'b0}}, ocl_wdata});
                `CSR_ADDR_ALLOW:  allow_seen = 1'b1;
                `CSR_ADDR_DONE:   done_seen = 1'b1;
                default:          ;
            endcase
        end
        if (ocl_bvalid && ocl_bready) begin
            ocl_b_cnt++;
            if (ocl_b_cnt > ocl_aw_cnt)
                failure("ocl B response without an open write");
        end
    endtask

    task automatic watch_ddr();
        int                     lanes;
        logic [`CAP_BEAT_W-1:0] exp_beat;
        if (ddr_awvalid && !allow_seen)
            failure("ddr_awvalid raised before ALLOW_DDR_W was written");
        if (ddr_awvalid && ddr_awready) begin
            check_value("ddr_awaddr", ddr_aw_cnt * `CAP_LINE_BYTES, ddr_awaddr);
            ddr_aw_cnt++;
        end
        if (ddr_wvalid && ddr_wready) begin
            if (irq_pulses != 0)
                failure("DDR line written after the interrupt");
            // a partial line only fills the lanes still owed
            lanes = (ref_q.size() < `CAP_BEATS) ? ref_q.size() : `CAP_BEATS;
            if (lanes == 0)
                failure("DDR line written with no beat outstanding");
            for (int k = 0; k < lanes; k++) begin
                exp_beat = ref_q.pop_front();
                check_value($sformatf("ddr_wdata lane %0d of line %0d", k, lines), exp_beat,
                            ddr_wdata[k*`CAP_BEAT_W +: `CAP_BEAT_W]);
            end
            lines++;
        end
    endtask

    task automatic end_checks();
        check_value("ddr_awvalid handshakes", exp_lines, ddr_aw_cnt);
        check_value("pcis_bvalid handshakes", exp_bursts, pcis_b_cnt);
        check_value("ocl_bvalid handshakes", exp_ocl_writes, ocl_b_cnt);
        check_value("DDR lines", exp_lines, lines);
        check_value("irq_req pulses", 1, irq_pulses);
        if (ref_q.size() != 0)
            failure($sformatf("%0d beats never reached DDR", ref_q.size()));
    endtask

    always @(posedge clk) begin
        if (rstn) begin
            watch_irq();
            watch_pcis();
            watch_ocl();
            watch_ddr();
            if (final_check && !checked) begin
                checked = 1'b1;
                end_checks();
            end
        end
    end

endmodule

//--- tests/tb_capture.sv
`timescale 1ns/1ps
`include "capture_defs.svh"

module tb_capture;

    typedef enum logic [1:0] {OP_PCIS, OP_OCL, OP_IDLE, OP_IRQ} op_e;

    typedef struct packed {
        op_e         op;
        logic [5:0]  id;
        logic [7:0]  len;    // PCIS lines minus one, or idle cycles
        logic [31:0] addr;
        logic [31:0] data;
        logic [15:0] beats;  // beats this row adds to the stream
    } row_t;

    localparam int NUM_ROWS = 12;

    logic                       clk;
    logic                       rstn;
    logic [5:0]                 pcis_awid;
    logic [7:0]                 pcis_awlen;
    logic                       pcis_awvalid;
    logic                       pcis_awready;
    logic [`CAP_LINE_W-1:0]     pcis_wdata;
    logic                       pcis_wlast;
    logic                       pcis_wvalid;
    logic                       pcis_wready;
    logic [5:0]                 pcis_bid;
    logic                       pcis_bvalid;
    logic                       pcis_bready;
    logic [31:0]                ocl_awaddr;
    logic                       ocl_awvalid;
    logic                       ocl_awready;
    logic [31:0]                ocl_wdata;
    logic                       ocl_wvalid;
    logic                       ocl_wready;
    logic                       ocl_bvalid;
    logic                       ocl_bready;
    logic [`CAP_DDR_ADDR_W-1:0] ddr_awaddr;
    logic                       ddr_awvalid;
    logic                       ddr_awready;
    logic [`CAP_LINE_W-1:0]     ddr_wdata;
    logic                       ddr_wvalid;
    logic                       ddr_wready;
    logic                       irq_req;
    logic                       final_check;
    int                         exp_beats;
    int                         exp_bursts;
    int                         exp_ocl_writes;
    int                         errors;
    int                         cycles;
    int                         limit;
    integer                     seed = 32'h9e29;
    row_t                       rows [NUM_ROWS];

    capture_top UUT (.*);

    capture_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic row_t make_row(input op_e op, input logic [5:0] id,
                                      input logic [7:0] len, input logic [31:0] addr,
                                      input logic [31:0] data, input logic [15:0] beats);
        row_t r;
        r.op    = op;
        r.id    = id;
        r.len   = len;
        r.addr  = addr;
        r.data  = data;
        r.beats = beats;
        return r;
    endfunction

    task automatic fill_table();
        // first burst lands before DDR writes are allowed
        rows[0]  = make_row(OP_PCIS, 6'd3, 8'd0, 32'd0, 32'd0, 16'd8);
        rows[1]  = make_row(OP_IDLE, 6'd0, 8'd20, 32'd0, 32'd0, 16'd0);
        rows[2]  = make_row(OP_OCL, 6'd0, 8'd0, `CSR_ADDR_ALLOW, 32'd1, 16'd0);
        rows[3]  = make_row(OP_PCIS, 6'd5, 8'd2, 32'd0, 32'd0, 16'd24);
        rows[4]  = make_row(OP_OCL, 6'd0, 8'd0, `CSR_ADDR_INJECT, 32'hcafe0001, 16'd1);
        rows[5]  = make_row(OP_PCIS, 6'd9, 8'd1, 32'd0, 32'd0, 16'd16);
        rows[6]  = make_row(OP_OCL, 6'd0, 8'd0, `CSR_ADDR_INJECT, 32'h0badf00d, 16'd1);
        rows[7]  = make_row(OP_OCL, 6'd0, 8'd0, `CSR_ADDR_INJECT, 32'h12345678, 16'd1);
        rows[8]  = make_row(OP_PCIS, 6'd2, 8'd0, 32'd0, 32'd0, 16'd8);
        rows[9]  = make_row(OP_OCL, 6'd0, 8'd0, `CSR_ADDR_DONE, 32'd1, 16'd0);
        rows[10] = make_row(OP_IRQ, 6'd0, 8'd0, 32'd0, 32'd0, 16'd0);
        // quiet tail to catch a second pulse
        rows[11] = make_row(OP_IDLE, 6'd0, 8'd20, 32'd0, 32'd0, 16'd0);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [`CAP_LINE_W-1:0] random_line();
        logic [`CAP_LINE_W-1:0] line;
        for (int k = 0; k < `CAP_LINE_W / 32; k++)
            line[k*32 +: 32] = $random(seed);
        return line;
    endfunction

    task automatic pcis_burst(input logic [5:0] id, input logic [7:0] len);
        pcis_awid    = id;
        pcis_awlen   = len;
        pcis_awvalid = 1'b1;
        while (!pcis_awready)
            next_cycle();
        next_cycle();
        pcis_awvalid = 1'b0;
        for (int n = 0; n <= len; n++) begin
            pcis_wdata  = random_line();
            pcis_wlast  = (n == len);
            pcis_wvalid = 1'b1;
            while (!pcis_wready)
                next_cycle();
            next_cycle();
            pcis_wvalid = 1'b0;
            pcis_wlast  = 1'b0;
        end
        while (!pcis_bvalid)
            next_cycle();
        next_cycle();
    endtask

    task automatic ocl_write(input logic [31:0] addr, input logic [31:0] data);
        ocl_awaddr  = addr;
        ocl_awvalid = 1'b1;
        while (!ocl_awready)
            next_cycle();
        next_cycle();
        ocl_awvalid = 1'b0;
        ocl_wdata   = data;
        ocl_wvalid  = 1'b1;
        while (!ocl_wready)
            next_cycle();
        next_cycle();
        ocl_wvalid = 1'b0;
        while (!ocl_bvalid)
            next_cycle();
        next_cycle();
    endtask

    task automatic apply_row(input row_t r);
        case (r.op)
            OP_PCIS: pcis_burst(r.id, r.len);
            OP_OCL:  ocl_write(r.addr, r.data);
            OP_IDLE: repeat (r.len) next_cycle();
            OP_IRQ: begin
                while (!irq_req)
                    next_cycle();
            end
            default: ;
        endcase
    endtask

    initial begin
        fill_table();
        for (int i = 0; i < NUM_ROWS; i++) begin
            exp_beats += rows[i].beats;
            if (rows[i].op == OP_PCIS)
                exp_bursts++;
            if (rows[i].op == OP_OCL)
                exp_ocl_writes++;
        end
        limit = 16 + 40 * exp_beats + 200;

        rstn         = 1'b0;
        pcis_awid    = '0;
        pcis_awlen   = '0;
        pcis_awvalid = 1'b0;
        pcis_wdata   = '0;
        pcis_wlast   = 1'b0;
        pcis_wvalid  = 1'b0;
        pcis_bready  = 1'b1;
        ocl_awaddr   = '0;
        ocl_awvalid  = 1'b0;
        ocl_wdata    = '0;
        ocl_wvalid   = 1'b0;
        ocl_bready   = 1'b1;
        ddr_awready  = 1'b1;
        ddr_wready   = 1'b1;
        final_check  = 1'b0;

        repeat (16) @(posedge clk);
        #1;
        rstn = 1'b1;

        for (int i = 0; i < NUM_ROWS; i++)
            apply_row(rows[i]);

        final_check = 1'b1;
        next_cycle();
        next_cycle();

        $display("summary: %0d rows, %0d beats, %0d errors", NUM_ROWS, exp_beats, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- src.f
+incdir+include
design/stream_pkg.sv
design/csr_pkg.sv
design/beat_stream_if.sv
design/pcis_write_slave.sv
design/ocl_csr.sv
design/stream_arbiter.sv
design/ddr_line_writer.sv
design/capture_top.sv
tests/capture_checker.sv
tests/tb_capture.sv
